// ==== project.f ====
+incdir+hw
hw/aesPkg.sv
hw/sBoxRom.sv
hw/keyExpander.sv
hw/roundKeyStore.sv
hw/cipherRound.sv
hw/aesController.sv
hw/aesCore.sv
verif/aesChecker.sv
verif/aesCoreTb.sv

// ==== run.sh ====
#!/bin/sh
# Builds the AES-128 testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

verilator --binary -j 0 --timescale 1ns/1ns -f project.f \
    --top-module aesCoreTb -Mdir obj_dir -o simAes
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/simAes > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "ALL TESTS PASSED" sim.log; then
    exit 0
fi
exit 1

// ==== verif/aesCoreTb.sv ====
`timescale 1ns/1ns
`include "aes_config.svh"

module aesCoreTb
    import aesPkg::*;
();

    localparam int ClkHalf = 20;
    localparam int NumRandom = 4;
    localparam int NumOps = 3 + 4 * NumRandom;

    // Test kinds as the checker names them
    localparam int FipsEnc = 0;
    localparam int FipsDec = 1;
    localparam int RandEnc = 2;
    localparam int RandDec = 3;
    localparam int TripEnc = 4;
    localparam int TripDec = 5;
    localparam int Ignored = 6;

    // FIPS-197 appendix C.1
    localparam blockT FipsKey = 128'h000102030405060708090a0b0c0d0e0f;
    localparam blockT FipsPt = 128'h00112233445566778899aabbccddeeff;
    localparam blockT FipsCt = 128'h69c4e0d86a7b0430d8cdb78070b4c55a;

    logic   clk;
    logic   rst;
    logic   start;
    logic   decrypt;
    blockT  key;
    blockT  dataIn;
    logic   ready;
    logic   done;
    blockT  dataOut;
    blockT  expData;
    int     testKind;
    logic   allDone;
    int     testCount;
    int     failCount;
    integer seed;

    byteT  sbox [0:255];
    byteT  invSbox [0:255];
    blockT roundKeys [0:`AES_ROUNDS];

    aesCore dut (
        .clk     (clk),
        .rst     (rst),
        .start   (start),
        .decrypt (decrypt),
        .key     (key),
        .dataIn  (dataIn),
        .ready   (ready),
        .done    (done),
        .dataOut (dataOut)
    );

    aesChecker resultCheck (
        .clk       (clk),
        .rst       (rst),
        .start     (start),
        .ready     (ready),
        .done      (done),
        .dataOut   (dataOut),
        .expData   (expData),
        .testKind  (testKind),
        .allDone   (allDone),
        .testCount (testCount),
        .failCount (failCount)
    );

    initial clk = 1'b0;
    always #ClkHalf clk = ~clk;

    function automatic byteT gfMul(input byteT a, input byteT b);
        byteT p;
        byteT x;
        p = 8'h00;
        x = a;
        for (int i = 0; i < 8; i++) begin
            if (b[i]) p = p ^ x;
            x = {x[6:0], 1'b0} ^ (x[7] ? `AES_GF_POLY : 8'h00);
        end
        return p;
    endfunction

    // S-box from the field inverse and the affine map
    task automatic buildTables();
        byteT inv;
        for (int a = 0; a < 256; a++) begin
            inv = 8'h00;
            for (int b = 1; b < 256; b++) begin
                if (gfMul(byteT'(a), byteT'(b)) == 8'h01) inv = byteT'(b);
            end
            sbox[a] = inv ^ {inv[6:0], inv[7]} ^ {inv[5:0], inv[7:6]}
                      ^ {inv[4:0], inv[7:5]} ^ {inv[3:0], inv[7:4]} ^ 8'h63;
        end
        for (int y = 0; y < 256; y++) begin
            for (int x = 0; x < 256; x++) begin
                if (sbox[x] == byteT'(y)) invSbox[y] = byteT'(x);
            end
        end
    endtask

    task automatic expandKey(input blockT k);
        wordT w [0:43];
        wordT t;
        byteT rc;
        rc = 8'h01;
        for (int i = 0; i < 4; i++) w[i] = k[127-32*i -: 32];
        for (int i = 4; i < 44; i++) begin
            t = w[i-1];
            if (i % 4 == 0) begin
                t = {sbox[t[23:16]], sbox[t[15:8]], sbox[t[7:0]], sbox[t[31:24]]}
                    ^ {rc, 24'h000000};
                rc = gfMul(rc, 8'h02);
            end
            w[i] = w[i-4] ^ t;
        end
        for (int r = 0; r <= `AES_ROUNDS; r++) begin
            roundKeys[r] = {w[4*r], w[4*r+1], w[4*r+2], w[4*r+3]};
        end
    endtask

    function automatic blockT subBytes(input blockT s, input logic inv);
        blockT r;
        for (int i = 0; i < 16; i++) begin
            r[127-8*i -: 8] = inv ? invSbox[s[127-8*i -: 8]] : sbox[s[127-8*i -: 8]];
        end
        return r;
    endfunction

    // Row r of the 4*col+row byte layout rotates left by r
    function automatic blockT shiftRows(input blockT s, input logic inv);
        blockT r;
        int    moved;
        for (int c = 0; c < 4; c++) begin
            for (int row = 0; row < 4; row++) begin
                moved = 4 * ((c + row) % 4) + row;
                if (inv) r[127-8*moved -: 8] = s[127-8*(4*c+row) -: 8];
                else r[127-8*(4*c+row) -: 8] = s[127-8*moved -: 8];
            end
        end
        return r;
    endfunction

    function automatic blockT mixColumns(input blockT s, input logic inv);
        logic [31:0] coef;
        blockT       r;
        byteT        acc;
        coef = inv ? 32'h0e0b0d09 : 32'h02030101;
        for (int c = 0; c < 4; c++) begin
            for (int row = 0; row < 4; row++) begin
                acc = 8'h00;
                for (int j = 0; j < 4; j++) begin
                    acc = acc ^ gfMul(s[127-8*(4*c+j) -: 8], coef[31-8*((j+4-row)%4) -: 8]);
                end
                r[127-8*(4*c+row) -: 8] = acc;
            end
        end
        return r;
    endfunction

    task automatic encryptBlock(input blockT k, input blockT pt, output blockT ct);
        blockT s;
        expandKey(k);
        s = pt ^ roundKeys[0];
        for (int r = 1; r <= `AES_ROUNDS; r++) begin
            s = shiftRows(subBytes(s, 1'b0), 1'b0);
            if (r != `AES_ROUNDS) s = mixColumns(s, 1'b0);
            s = s ^ roundKeys[r];
        end
        ct = s;
    endtask

    task automatic decryptBlock(input blockT k, input blockT ct, output blockT pt);
        blockT s;
        expandKey(k);
        s = ct ^ roundKeys[`AES_ROUNDS];
        for (int r = `AES_ROUNDS - 1; r >= 0; r--) begin
            s = subBytes(shiftRows(s, 1'b1), 1'b1) ^ roundKeys[r];
            if (r != 0) s = mixColumns(s, 1'b1);
        end
        pt = s;
    endtask

    task automatic randomBlock(output blockT b);
        for (int i = 0; i < 4; i++) b = {b[95:0], $random(seed)};
    endtask

    // Runs one request and pulses a second start while busy when poke is set
    task automatic runOp(input int kind, input logic dec, input blockT k, input blockT d,
                         input blockT exp, input logic poke, output blockT result);
        @(posedge clk);
        while (!ready) @(posedge clk);
        start    <= 1'b1;
        decrypt  <= dec;
        key      <= k;
        dataIn   <= d;
        expData  <= exp;
        testKind <= kind;
        @(posedge clk);
        start <= 1'b0;
        if (poke) begin
            repeat (4) @(posedge clk);
            start   <= 1'b1;
            decrypt <= !dec;
            key     <= ~k;
            dataIn  <= ~d;
            @(posedge clk);
            start <= 1'b0;
        end
        @(posedge clk);
        while (!done) @(posedge clk);
        result = dataOut;
    endtask

    initial begin
        blockT k;
        blockT d;
        blockT exp;
        blockT ct;
        blockT got;

        seed = 95;
        rst = 1'b1;
        start = 1'b0;
        decrypt = 1'b0;
        key = '0;
        dataIn = '0;
        expData = '0;
        testKind = 0;
        allDone = 1'b0;
        buildTables();

        repeat (3) @(posedge clk);
        rst <= 1'b0;
        repeat (2) @(posedge clk);

        runOp(FipsEnc, 1'b0, FipsKey, FipsPt, FipsCt, 1'b0, got);
        runOp(FipsDec, 1'b1, FipsKey, FipsCt, FipsPt, 1'b0, got);

        for (int i = 0; i < NumRandom; i++) begin
            randomBlock(k);
            randomBlock(d);
            encryptBlock(k, d, exp);
            runOp(RandEnc, 1'b0, k, d, exp, 1'b0, got);
        end

        for (int i = 0; i < NumRandom; i++) begin
            randomBlock(k);
            randomBlock(d);
            decryptBlock(k, d, exp);
            runOp(RandDec, 1'b1, k, d, exp, 1'b0, got);
            // The DUT's own ciphertext must decrypt back to the block
            encryptBlock(k, d, exp);
            runOp(TripEnc, 1'b0, k, d, exp, 1'b0, ct);
            runOp(TripDec, 1'b1, k, ct, d, 1'b0, got);
        end

        randomBlock(k);
        randomBlock(d);
        encryptBlock(k, d, exp);
        runOp(Ignored, 1'b0, k, d, exp, 1'b1, got);

        @(posedge clk);
        allDone <= 1'b1;
        repeat (2) @(posedge clk);
        if (testCount != NumOps + 1) begin
            $display("Only %0d of %0d tests finished", testCount, NumOps + 1);
        end
        if (failCount == 0 && testCount == NumOps + 1) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

    // About 30 cycles per operation plus reset and slack
    initial begin
        #((NumOps * 30 + 50) * 2 * ClkHalf);
        $display("Timeout: the run did not finish in the allowed time");
        $display("SOME TESTS FAILED");
        $finish;
    end

endmodule

// ==== verif/aesChecker.sv ====
`timescale 1ns/1ns

module aesChecker
    import aesPkg::*;
(
    input  logic  clk,
    input  logic  rst,
    input  logic  start,
    input  logic  ready,
    input  logic  done,
    input  blockT dataOut,
    input  blockT expData,
    input  int    testKind,
    input  logic  allDone,
    output int    testCount,
    output int    failCount
);

    // Edges from the accepting edge to the one that sees done
    localparam int Latency = 22;

    blockT expQ [$];
    int    kindQ [$];
    logic  busy;
    logic  readyBad;
    logic  summaryShown;
    int    cycles;

    function automatic string kindName(input int kind);
        case (kind)
            0: return "fipsEncrypt";
            1: return "fipsDecrypt";
            2: return "randomEncrypt";
            3: return "randomDecrypt";
            4: return "roundTripEncrypt";
            5: return "roundTripDecrypt";
            6: return "ignoredStart";
            default: return "unknown";
        endcase
    endfunction

    task automatic finishTest();
        string name;
        blockT expected;
        name = kindName(kindQ.pop_front());
        expected = expQ.pop_front();
        testCount++;
        if (dataOut !== expected) begin
            $display("Fail %0s #%0d expected %h actual %h", name, testCount, expected, dataOut);
            failCount++;
        end else if (cycles != Latency) begin
            $display("Fail %0s #%0d latency expected %0d actual %0d",
                     name, testCount, Latency, cycles);
            failCount++;
        end else if (readyBad) begin
            $display("%0s #%0d: ready went high before done", name, testCount);
            failCount++;
        end else begin
            $display("Pass %0s #%0d result %h", name, testCount, dataOut);
        end
    endtask

    initial begin
        testCount = 0;
        failCount = 0;
        busy = 1'b0;
        readyBad = 1'b0;
        summaryShown = 1'b0;
        cycles = 0;

        // Idle outputs right after reset
        @(negedge rst);
        @(posedge clk);
        testCount++;
        if (ready !== 1'b1 || done !== 1'b0 || dataOut !== '0) begin
            $display("Fail resetState expected ready/done/dataOut 1/0/0 actual %b/%b/%h",
                     ready, done, dataOut);
            failCount++;
        end else begin
            $display("Pass resetState");
        end

        forever begin
            @(posedge clk);
            if (busy) begin
                cycles++;
                if (done) begin
                    busy = 1'b0;
                    finishTest();
                end else if (ready) begin
                    readyBad = 1'b1;
                end
            end else if (done) begin
                $display("A done pulse arrived with no request in flight");
                failCount++;
            end
            // Only a start seen while ready is high opens a test
            if (start && ready) begin
                expQ.push_back(expData);
                kindQ.push_back(testKind);
                busy = 1'b1;
                readyBad = 1'b0;
                cycles = 0;
            end
            if (allDone && !summaryShown) begin
                summaryShown = 1'b1;
                $display("Tests run %0d, passed %0d, failed %0d",
                         testCount, testCount - failCount, failCount);
            end
        end
    end

endmodule

// ==== hw/aesCore.sv ====
`timescale 1ns/1ns

module aesCore
    import aesPkg::*;
(
    input  logic  clk,
    input  logic  rst,
    input  logic  start,
    input  logic  decrypt,
    input  blockT key,
    input  blockT dataIn,
    output logic  ready,
    output logic  done,
    output blockT dataOut
);

    logic     expandStart;
    logic     expandDone;
    logic     keyWrite;
    roundIdxT keyWriteIdx;
    blockT    keyWriteData;
    roundIdxT roundIdx;
    logic     firstStep;
    logic     decryptMode;
    blockT    roundKey;
    blockT    roundOut;

    aesController controller (
        .clk         (clk),
        .rst         (rst),
        .start       (start),
        .decrypt     (decrypt),
        .dataIn      (dataIn),
        .expandDone  (expandDone),
        .roundOut    (roundOut),
        .expandStart (expandStart),
        .roundIdx    (roundIdx),
        .firstStep   (firstStep),
        .stateOut    (dataOut),
        .decryptMode (decryptMode),
        .ready       (ready),
        .done        (done)
    );

    keyExpander expander (
        .clk          (clk),
        .rst          (rst),
        .expandStart  (expandStart),
        .key          (key),
        .keyWrite     (keyWrite),
        .keyWriteIdx  (keyWriteIdx),
        .keyWriteData (keyWriteData),
        .expandDone   (expandDone)
    );

    roundKeyStore keyStore (
        .clk          (clk),
        .rst          (rst),
        .keyWrite     (keyWrite),
        .keyWriteIdx  (keyWriteIdx),
        .keyWriteData (keyWriteData),
        .roundIdx     (roundIdx),
        .roundKey     (roundKey)
    );

    // Shared round datapath fed back from the controller's state register
    cipherRound round (
        .decrypt   (decryptMode),
        .roundIdx  (roundIdx),
        .firstStep (firstStep),
        .stateIn   (dataOut),
        .roundKey  (roundKey),
        .roundOut  (roundOut)
    );

endmodule

// ==== hw/aesController.sv ====
`timescale 1ns/1ns
`include "aes_config.svh"

module aesController
    import aesPkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  logic     start,
    input  logic     decrypt,
    input  blockT    dataIn,
    input  logic     expandDone,
    input  blockT    roundOut,
    output logic     expandStart,
    output roundIdxT roundIdx,
    output logic     firstStep,
    output blockT    stateOut,
    output logic     decryptMode,
    output logic     ready,
    output logic     done
);

    localparam roundIdxT LastRound = `AES_ROUNDS;

    aesStateT state;
    roundIdxT stepCount;
    blockT    stateReg;
    logic     accept;

    assign ready  = (state == sIdle) || (state == sDone);
    assign done   = (state == sDone);
    assign accept = ready && start;

    // Expansion starts on the same edge that accepts the request
    assign expandStart = accept;

    assign firstStep = (state == sRound) && (stepCount == '0);

    // Decryption walks the round keys backwards
    assign roundIdx = decryptMode ? (LastRound - stepCount) : stepCount;

    assign stateOut = stateReg;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state       <= sIdle;
            stepCount   <= '0;
            decryptMode <= 1'b0;
            stateReg    <= '0;
        end else begin
            case (state)
                sIdle, sDone: begin
                    if (accept) begin
                        state       <= sExpand;
                        stepCount   <= '0;
                        decryptMode <= decrypt;
                        stateReg    <= dataIn;
                    end else begin
                        state <= sIdle;
                    end
                end
                sExpand: begin
                    if (expandDone) state <= sRound;
                end
                sRound: begin
                    stateReg <= roundOut;
                    if (stepCount == LastRound) begin
                        state <= sDone;
                    end else begin
                        stepCount <= stepCount + roundIdxT'(1);
                    end
                end
                default: begin
                    state <= sIdle;
                end
            endcase
        end
    end

endmodule

// ==== hw/cipherRound.sv ====
`timescale 1ns/1ns
`include "aes_config.svh"

module cipherRound
    import aesPkg::*;
(
    input  logic     decrypt,
    input  roundIdxT roundIdx,
    input  logic     firstStep,
    input  blockT    stateIn,
    input  blockT    roundKey,
    output blockT    roundOut
);

    localparam int BlockBits = `AES_BLOCK_BITS;
    localparam int NumBytes = BlockBits / 8;
    localparam roundIdxT LastRound = `AES_ROUNDS;

    // First row of the circulant column-mix matrices
    localparam logic [0:3][3:0] FwdCoef = 16'h2311;
    localparam logic [0:3][3:0] InvCoef = 16'hebd9;

    blockT subOut;
    blockT fwdShift;
    blockT fwdMix;
    blockT fwdOut;
    blockT invShift;
    blockT invSub;
    blockT invAdd;
    blockT invOut;

    function automatic byteT xtime(input byteT a);
        return {a[6:0], 1'b0} ^ (a[7] ? `AES_GF_POLY : 8'h00);
    endfunction

    function automatic byteT gfMul(input byteT a, input logic [3:0] m);
        byteT acc;
        byteT x;
        acc = '0;
        x = a;
        for (int k = 0; k < 4; k++) begin
            if (m[k]) acc = acc ^ x;
            x = xtime(x);
        end
        return acc;
    endfunction

    // Byte 4*col+row of the state with byte 0 in the top bits
    function automatic blockT shiftRows(input blockT s, input logic inv);
        blockT r;
        int src;
        r = '0;
        for (int c = 0; c < 4; c++) begin
            for (int row = 0; row < 4; row++) begin
                src = inv ? (c - row + 4) % 4 : (c + row) % 4;
                r[BlockBits-1-8*(4*c+row) -: 8] = s[BlockBits-1-8*(4*src+row) -: 8];
            end
        end
        return r;
    endfunction

    function automatic blockT mixCols(input blockT s, input logic [0:3][3:0] coef);
        blockT r;
        byteT acc;
        r = '0;
        for (int c = 0; c < 4; c++) begin
            for (int row = 0; row < 4; row++) begin
                acc = '0;
                for (int j = 0; j < 4; j++) begin
                    acc = acc ^ gfMul(s[BlockBits-1-8*(4*c+j) -: 8], coef[(j - row + 4) % 4]);
                end
                r[BlockBits-1-8*(4*c+row) -: 8] = acc;
            end
        end
        return r;
    endfunction

    for (genvar i = 0; i < NumBytes; i++) begin : gSubBytes
        sBoxRom #(.Inverse(0)) fwdBox (
            .addr(stateIn[8*i +: 8]),
            .data(subOut[8*i +: 8])
        );
        sBoxRom #(.Inverse(1)) invBox (
            .addr(invShift[8*i +: 8]),
            .data(invSub[8*i +: 8])
        );
    end

    // Forward round without the column mix in the last one
    assign fwdShift = shiftRows(subOut, 1'b0);
    assign fwdMix   = mixCols(fwdShift, FwdCoef);
    assign fwdOut   = ((roundIdx == LastRound) ? fwdShift : fwdMix) ^ roundKey;

    // Inverse round with the key added before the inverse mix
    assign invShift = shiftRows(stateIn, 1'b1);
    assign invAdd   = invSub ^ roundKey;
    assign invOut   = (roundIdx == '0) ? invAdd : mixCols(invAdd, InvCoef);

    assign roundOut = firstStep ? (stateIn ^ roundKey) : (decrypt ? invOut : fwdOut);

endmodule

// ==== hw/roundKeyStore.sv ====
`timescale 1ns/1ns
`include "aes_config.svh"

module roundKeyStore
    import aesPkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  logic     keyWrite,
    input  roundIdxT keyWriteIdx,
    input  blockT    keyWriteData,
    input  roundIdxT roundIdx,
    output blockT    roundKey
);

    localparam roundIdxT LastKey = `AES_ROUNDS;

    blockT keys [0:`AES_ROUNDS];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            keys <= '{default: '0};
        end else if (keyWrite && (keyWriteIdx <= LastKey)) begin
            keys[keyWriteIdx] <= keyWriteData;
        end
    end

    // Indexes past the last key read as zero
    assign roundKey = (roundIdx <= LastKey) ? keys[roundIdx] : '0;

endmodule

// ==== hw/keyExpander.sv ====
`timescale 1ns/1ns
`include "aes_config.svh"

module keyExpander
    import aesPkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  logic     expandStart,
    input  blockT    key,
    output logic     keyWrite,
    output roundIdxT keyWriteIdx,
    output blockT    keyWriteData,
    output logic     expandDone
);

    localparam int KeyWords = `AES_KEY_BITS / 32;
    localparam roundIdxT LastKey = `AES_ROUNDS;

    logic     busy;
    roundIdxT step;
    byteT     rcon;
    blockT    curKey;
    blockT    nextKey;
    wordT     rotWord;
    wordT     subWord;
    wordT     chain;

    // RotWord on the last column, then SubWord
    assign rotWord = {curKey[23:0], curKey[31:24]};

    for (genvar b = 0; b < 4; b++) begin : gSubWord
        sBoxRom #(.Inverse(0)) subBox (
            .addr(rotWord[8*b +: 8]),
            .data(subWord[8*b +: 8])
        );
    end

    always_comb begin
        chain = subWord ^ {rcon, 24'h000000};
        nextKey = '0;
        for (int i = 0; i < KeyWords; i++) begin
            chain = chain ^ curKey[`AES_KEY_BITS-1-32*i -: 32];
            nextKey[`AES_KEY_BITS-1-32*i -: 32] = chain;
        end
    end

    // Key 0 goes straight from the input on the accepting edge
    assign keyWrite     = expandStart || busy;
    assign keyWriteIdx  = expandStart ? roundIdxT'(0) : step;
    assign keyWriteData = expandStart ? key : nextKey;
    assign expandDone   = busy && (step == LastKey);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            busy <= 1'b0;
            step <= '0;
        end else if (expandStart) begin
            busy <= 1'b1;
            step <= roundIdxT'(1);
        end else if (busy) begin
            busy <= !expandDone;
            step <= step + roundIdxT'(1);
        end
    end

    always_ff @(posedge clk) begin
        if (expandStart) begin
            curKey <= key;
            rcon   <= 8'h01;
        end else if (busy) begin
            curKey <= nextKey;
            rcon   <= {rcon[6:0], 1'b0} ^ (rcon[7] ? `AES_GF_POLY : 8'h00);
        end
    end

endmodule

// ==== hw/sBoxRom.sv ====
`timescale 1ns/1ns

module sBoxRom
    import aesPkg::*;
#(
    parameter int Inverse = 0
) (
    input  byteT addr,
    output byteT data
);

    // Entry 0 sits in the leftmost byte
    localparam logic [0:255][7:0] FwdTable = {
        128'h637c777b_f26b6fc5_3001672b_fed7ab76,
        128'hca82c97d_fa5947f0_add4a2af_9ca472c0,
        128'hb7fd9326_363ff7cc_34a5e5f1_71d83115,
        128'h04c723c3_1896059a_071280e2_eb27b275,
        128'h09832c1a_1b6e5aa0_523bd6b3_29e32f84,
        128'h53d100ed_20fcb15b_6acbbe39_4a4c58cf,
        128'hd0efaafb_434d3385_45f9027f_503c9fa8,
        128'h51a3408f_929d38f5_bcb6da21_10fff3d2,
        128'hcd0c13ec_5f974417_c4a77e3d_645d1973,
        128'h60814fdc_222a9088_46eeb814_de5e0bdb,
        128'he0323a0a_4906245c_c2d3ac62_9195e479,
        128'he7c8376d_8dd54ea9_6c56f4ea_657aae08,
        128'hba78252e_1ca6b4c6_e8dd741f_4bbd8b8a,
        128'h703eb566_4803f60e_613557b9_86c11d9e,
        128'he1f89811_69d98e94_9b1e87e9_ce5528df,
        128'h8ca1890d_bfe64268_41992d0f_b054bb16
    };

    localparam logic [0:255][7:0] InvTable = {
        128'h52096ad5_3036a538_bf40a39e_81f3d7fb,
        128'h7ce33982_9b2fff87_348e4344_c4dee9cb,
        128'h547b9432_a6c2233d_ee4c950b_42fac34e,
        128'h082ea166_28d924b2_765ba249_6d8bd125,
        128'h72f8f664_86689816_d4a45ccc_5d65b692,
        128'h6c704850_fdedb9da_5e154657_a78d9d84,
        128'h90d8ab00_8cbcd30a_f7e45805_b8b34506,
        128'hd02c1e8f_ca3f0f02_c1afbd03_01138a6b,
        128'h3a911141_4f67dcea_97f2cfce_f0b4e673,
        128'h96ac7422_e7ad3585_e2f937e8_1c75df6e,
        128'h47f11a71_1d29c589_6fb7620e_aa18be1b,
        128'hfc563e4b_c6d27920_9adbc0fe_78cd5af4,
        128'h1fdda833_8807c731_b1121059_2780ec5f,
        128'h60517fa9_19b54a0d_2de57a9f_93c99cef,
        128'ha0e03b4d_ae2af5b0_c8ebbb3c_83539961,
        128'h172b047e_ba77d626_e1691463_55210c7d
    };

    generate
        if (Inverse != 0) begin : gInv
            assign data = InvTable[addr];
        end else begin : gFwd
            assign data = FwdTable[addr];
        end
    endgenerate

endmodule

// ==== hw/aesPkg.sv ====
`include "aes_config.svh"

package aesPkg;

    // One state byte
    typedef logic [7:0] byteT;

    // One key-schedule column
    typedef logic [31:0] wordT;

    // Full state or round key
    typedef logic [`AES_BLOCK_BITS-1:0] blockT;

    // Round index, 0 to 10
    typedef logic [3:0] roundIdxT;

    typedef enum logic [1:0] {
        sIdle,
        sExpand,
        sRound,
        sDone
    } aesStateT;

endpackage

// ==== hw/aes_config.svh ====
`ifndef AES_CONFIG_SVH
`define AES_CONFIG_SVH

// Data path sizes
`define AES_BLOCK_BITS 128
`define AES_KEY_BITS 128

// Rounds for a 128-bit key with one more round key than rounds
`define AES_ROUNDS 10

// Low byte of x^8 + x^4 + x^3 + x + 1
`define AES_GF_POLY 8'h1b

`endif
